//--- rtl/rap_pkg.sv
package rap_pkg;

  // Motor and queue sizing
  localparam int motor_count = 2;
  localparam int motor_bits = $clog2(motor_count);
  localparam int queue_depth = 4;
  localparam int queue_ptr_bits = 2;
  localparam int count_bits = 3;                    // Holds 0 to queue_depth

  // Move datapath widths
  localparam int rate_bits = 16;
  localparam int duration_bits = 16;

  // Command framing
  localparam int move_arg_bytes = 6;
  localparam int arg_buf_bits = 8 * (move_arg_bytes - 1);

  // Reset stretcher counter width
  localparam int reset_stretch_bits = 8;

  typedef enum logic [7:0] {
    cmd_nop         = 8'h00,
    cmd_set_enable  = 8'h01,                        // 1 byte, enable mask
    cmd_queue_move  = 8'h02,                        // 6 bytes, see decoder
    cmd_read_status = 8'h03,                        // 1 dummy byte, reply out
    cmd_halt_all    = 8'h04
  } cmd_e;

  typedef struct packed {
    logic                     dir;
    logic [rate_bits-1:0]     increment;            // Added per cycle
    logic [duration_bits-1:0] duration;             // In CLK cycles
  } move_t;

  typedef struct packed {
    logic                  wr_en;
    logic [motor_bits-1:0] motor;
    move_t                 move;
  } move_write_t;

  typedef struct packed {
    logic                  req;
    logic [motor_bits-1:0] motor;
  } move_read_req_t;

  typedef struct packed {
    logic                  valid;
    logic [motor_bits-1:0] motor;                   // Owner of this response
    move_t                 move;
  } move_read_rsp_t;

endpackage

//--- rtl/spi_target.sv
`timescale 1ns/1ns

module spi_target (
  input  logic       CLK,
  input  logic       resetn,
  input  logic       sck,
  input  logic       cs,
  input  logic       copi,
  output logic       cipo,
  output logic [7:0] rx_byte,
  output logic       rx_strobe,
  output logic       frame_start,
  output logic       frame_end,
  input  logic [7:0] tx_byte
);

  logic [2:0] sck_q;                                // Two sync flops plus history
  logic [2:0] cs_q;
  logic [1:0] copi_q;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_fall;
  logic       cs_rise;
  logic       cs_active;
  logic [2:0] bit_cnt;
  logic [7:0] rx_shift;
  logic [7:0] tx_shift;

  assign sck_rise  = (sck_q[2:1] == 2'b01);
  assign sck_fall  = (sck_q[2:1] == 2'b10);
  assign cs_fall   = (cs_q[2:1] == 2'b10);
  assign cs_rise   = (cs_q[2:1] == 2'b01);
  assign cs_active = !cs_q[1];
  assign cipo      = tx_shift[7];                   // MSB first

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_q       <= '0;
      cs_q        <= '1;                            // Deselected
      copi_q      <= '0;
      bit_cnt     <= '0;
      tx_shift    <= '0;
      rx_strobe   <= 1'b0;
      frame_start <= 1'b0;
      frame_end   <= 1'b0;
    end else begin
      sck_q       <= {sck_q[1:0], sck};
      cs_q        <= {cs_q[1:0], cs};
      copi_q      <= {copi_q[0], copi};
      frame_start <= cs_fall;
      frame_end   <= cs_rise;
      rx_strobe   <= 1'b0;
      if (cs_rise) begin
        bit_cnt <= '0;
      end else if (cs_active && sck_rise) begin
        bit_cnt   <= bit_cnt + 3'd1;
        rx_strobe <= (bit_cnt == 3'd7);             // Eighth bit in
      end
      // Reply bits change on falling SCK, new byte once the counter wraps
      if (cs_fall) begin
        tx_shift <= tx_byte;
      end else if (cs_active && sck_fall) begin
        if (bit_cnt == 3'd0) begin
          tx_shift <= tx_byte;
        end else begin
          tx_shift <= {tx_shift[6:0], 1'b0};
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (cs_active && sck_rise) begin
      rx_shift <= {rx_shift[6:0], copi_q[1]};
      if (bit_cnt == 3'd7) begin
        rx_byte <= {rx_shift[6:0], copi_q[1]};
      end
    end
  end

endmodule

//--- rtl/command_decoder.sv
`timescale 1ns/1ns

module command_decoder (
  input  logic                                                   CLK,
  input  logic                                                   resetn,
  input  logic [7:0]                                             rx_byte,
  input  logic                                                   rx_strobe,
  input  logic                                                   frame_start,
  input  logic                                                   frame_end,
  output logic [7:0]                                             tx_byte,
  output rap_pkg::move_write_t                                   wr,
  output logic                                                   flush,
  output logic [rap_pkg::motor_count-1:0]                        en_mask,
  input  logic [rap_pkg::motor_count-1:0][rap_pkg::count_bits-1:0] fill_count
);

  import rap_pkg::*;

  typedef enum logic [1:0] {
    st_idle,                                        // No frame, or frame ignored
    st_opcode,
    st_args,
    st_reply
  } state_e;

  state_e                  state;
  cmd_e                    op;
  logic [2:0]              byte_cnt;
  logic [arg_buf_bits-1:0] arg_buf;
  logic [7:0]              status_byte;
  logic                    wr_stb;
  logic [motor_bits-1:0]   wr_motor;
  move_t                   wr_move;
  logic                    last_arg;

  assign wr = '{wr_en: wr_stb, motor: wr_motor, move: wr_move};
  assign last_arg = (byte_cnt == 3'(move_arg_bytes - 1));

  // One nibble of fill count per motor
  always_comb begin
    status_byte = '0;
    for (int m = 0; m < motor_count; m++) begin
      status_byte[4*m +: 4] = 4'(fill_count[m]);
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state    <= st_idle;
      op       <= cmd_nop;
      byte_cnt <= '0;
      tx_byte  <= '0;
      wr_stb   <= 1'b0;
      flush    <= 1'b0;
      en_mask  <= '0;
    end else begin
      wr_stb <= 1'b0;
      flush  <= 1'b0;
      if (frame_start) begin
        state    <= st_opcode;
        byte_cnt <= '0;
      end else if (frame_end) begin
        state   <= st_idle;
        tx_byte <= '0;
      end else if (rx_strobe) begin
        case (state)
          st_opcode: begin
            byte_cnt <= '0;
            op       <= cmd_e'(rx_byte);
            case (cmd_e'(rx_byte))
              cmd_nop:         state <= st_opcode;
              cmd_set_enable:  state <= st_args;
              cmd_queue_move:  state <= st_args;
              cmd_read_status: begin
                tx_byte <= status_byte;             // Goes out on the dummy byte
                state   <= st_reply;
              end
              cmd_halt_all:    flush <= 1'b1;
              default:         state <= st_idle;    // Drop rest of frame
            endcase
          end
          st_args: begin
            byte_cnt <= byte_cnt + 3'd1;
            if (op == cmd_set_enable) begin
              en_mask <= rx_byte[motor_count-1:0];
              state   <= st_opcode;
            end else if (last_arg) begin
              wr_stb <= 1'b1;
              state  <= st_opcode;
            end
          end
          st_reply: begin
            tx_byte <= '0;
            state   <= st_opcode;
          end
          default: state <= st_idle;
        endcase
      end
    end
  end

  // Byte order: motor, dir, inc hi, inc lo, dur hi, dur lo
  always_ff @(posedge CLK) begin
    if (rx_strobe && state == st_args) begin
      arg_buf <= {arg_buf[arg_buf_bits-9:0], rx_byte};
      if (last_arg) begin
        wr_motor         <= arg_buf[32 +: motor_bits];
        wr_move.dir      <= arg_buf[24];
        wr_move.increment <= arg_buf[23:8];
        wr_move.duration <= {arg_buf[7:0], rx_byte};
      end
    end
  end

endmodule

//--- rtl/move_buffer.sv
`timescale 1ns/1ns

module move_buffer (
  input  logic                                                     CLK,
  input  logic                                                     resetn,
  input  rap_pkg::move_write_t                                     wr,
  input  logic                                                     flush,
  input  rap_pkg::move_read_req_t                                  rd_req,
  output rap_pkg::move_read_rsp_t                                  rd_rsp,
  output logic [rap_pkg::motor_count-1:0][rap_pkg::count_bits-1:0] fill_count
);

  import rap_pkg::*;

  move_t                                        mem [motor_count*queue_depth];
  logic [motor_count-1:0][queue_ptr_bits-1:0]   head;
  logic [motor_count-1:0][queue_ptr_bits-1:0]   tail;
  logic [motor_count-1:0]                       wr_sel;
  logic [motor_count-1:0]                       rd_sel;
  logic                                         wr_ok;
  logic                                         rd_ok;
  logic                                         rsp_valid;
  logic [motor_bits-1:0]                        rsp_motor;
  move_t                                        rsp_move;

  assign wr_ok = wr.wr_en && !flush
                 && (fill_count[wr.motor] != count_bits'(queue_depth));   // Full drops
  assign rd_ok = rd_req.req && !flush && (fill_count[rd_req.motor] != '0);

  assign rd_rsp = '{valid: rsp_valid, motor: rsp_motor, move: rsp_move};

  always_comb begin
    wr_sel = '0;
    rd_sel = '0;
    wr_sel[wr.motor]     = wr_ok;
    rd_sel[rd_req.motor] = rd_ok;
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      head       <= '0;
      tail       <= '0;
      fill_count <= '0;
      rsp_valid  <= 1'b0;
    end else if (flush) begin
      head       <= '0;                             // Empties every queue
      tail       <= '0;
      fill_count <= '0;
      rsp_valid  <= 1'b0;
    end else begin
      rsp_valid <= rd_ok;
      for (int m = 0; m < motor_count; m++) begin
        if (wr_sel[m]) begin
          tail[m] <= tail[m] + 1'b1;                // Wraps at queue_depth
        end
        if (rd_sel[m]) begin
          head[m] <= head[m] + 1'b1;
        end
        if (wr_sel[m] && !rd_sel[m]) begin
          fill_count[m] <= fill_count[m] + 1'b1;
        end else if (!wr_sel[m] && rd_sel[m]) begin
          fill_count[m] <= fill_count[m] - 1'b1;
        end
      end
    end
  end

  // Slot address is motor index over ring pointer
  always_ff @(posedge CLK) begin
    if (wr_ok) begin
      mem[{wr.motor, tail[wr.motor]}] <= wr.move;
    end
    if (rd_ok) begin
      rsp_motor <= rd_req.motor;
      rsp_move  <= mem[{rd_req.motor, head[rd_req.motor]}];
    end
  end

endmodule

//--- rtl/move_arbiter.sv
`timescale 1ns/1ns

module move_arbiter (
  input  logic                    CLK,
  input  logic                    resetn,
  input  rap_pkg::move_read_req_t req [rap_pkg::motor_count],
  output rap_pkg::move_read_req_t grant
);

  import rap_pkg::*;

  logic [motor_bits-1:0] rr_ptr;                    // Highest priority this cycle
  logic [motor_bits-1:0] pick;
  logic                  found;

  // Search from rr_ptr upward, wrapping
  always_comb begin
    int idx;
    found = 1'b0;
    pick  = rr_ptr;
    for (int i = 0; i < motor_count; i++) begin
      idx = (int'(rr_ptr) + i) % motor_count;
      if (!found && req[idx].req) begin
        found = 1'b1;
        pick  = motor_bits'(idx);
      end
    end
  end

  assign grant = '{req: found, motor: req[pick].motor};

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      rr_ptr <= '0;
    end else if (found) begin
      if (pick == motor_bits'(motor_count - 1)) begin
        rr_ptr <= '0;
      end else begin
        rr_ptr <= pick + 1'b1;                      // Winner goes last
      end
    end
  end

endmodule

//--- rtl/step_generator.sv
`timescale 1ns/1ns

module step_generator (
  input  logic                            CLK,
  input  logic                            resetn,
  input  logic [rap_pkg::motor_bits-1:0]  index,
  input  logic                            enable,
  input  logic                            halt,
  input  logic                            queue_nonempty,
  output rap_pkg::move_read_req_t         rd_req,
  input  rap_pkg::move_read_rsp_t         rd_rsp,
  output logic                            step,
  output logic                            dir,
  output logic                            idle
);

  import rap_pkg::*;

  typedef enum logic [1:0] {
    gen_idle,
    gen_fetch,                                      // Waiting for the move memory
    gen_run
  } gen_state_e;

  gen_state_e               state;
  logic [rate_bits-1:0]     increment;
  logic [rate_bits-1:0]     acc;
  logic [rate_bits:0]       sum;
  logic [duration_bits-1:0] remaining;
  logic                     rsp_hit;
  logic                     start_req;

  assign rsp_hit   = rd_rsp.valid && (rd_rsp.motor == index);
  assign start_req = (state == gen_idle) && enable && queue_nonempty && !halt;

  // Request drops as soon as our response shows up
  assign rd_req.req   = start_req || ((state == gen_fetch) && !rsp_hit && !halt);
  assign rd_req.motor = index;

  assign sum  = {1'b0, acc} + {1'b0, increment};
  assign step = (state == gen_run) && sum[rate_bits];   // Carry out of the accumulator
  assign idle = (state == gen_idle);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state <= gen_idle;
      dir   <= 1'b0;
    end else if (halt) begin
      state <= gen_idle;
    end else begin
      case (state)
        gen_idle: begin
          if (start_req) begin
            state <= gen_fetch;
          end
        end
        gen_fetch: begin
          if (rsp_hit) begin
            dir <= rd_rsp.move.dir;
            if (rd_rsp.move.duration == '0) begin
              state <= gen_idle;                    // Empty move, nothing to run
            end else begin
              state <= gen_run;
            end
          end
        end
        gen_run: begin
          if (remaining == duration_bits'(1)) begin
            state <= gen_idle;
          end
        end
        default: state <= gen_idle;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (state == gen_fetch && rsp_hit) begin
      acc       <= '0;                              // Fresh phase per move
      increment <= rd_rsp.move.increment;
      remaining <= rd_rsp.move.duration;
    end else if (state == gen_run) begin
      acc       <= sum[rate_bits-1:0];
      remaining <= remaining - 1'b1;
    end
  end

endmodule

//--- rtl/rap_core.sv
`timescale 1ns/1ns

module rap_core (
  input  logic                            CLK,
  input  logic                            resetn,
  input  logic                            sck,
  input  logic                            cs,
  input  logic                            copi,
  output logic                            cipo,
  input  logic                            halt,
  output logic [rap_pkg::motor_count-1:0] step,
  output logic [rap_pkg::motor_count-1:0] dir,
  output logic [rap_pkg::motor_count-1:0] en,
  output logic                            buffer_dtr,
  output logic                            move_done
);

  import rap_pkg::*;

  logic [reset_stretch_bits-1:0]              reset_cnt;
  logic                                       core_resetn;
  logic                                       halt_q;
  logic                                       halt_all;
  logic [7:0]                                 rx_byte;
  logic                                       rx_strobe;
  logic                                       frame_start;
  logic                                       frame_end;
  logic [7:0]                                 tx_byte;
  move_write_t                                wr;
  logic                                       dec_flush;
  logic [motor_count-1:0][count_bits-1:0]     fill_count;
  move_read_req_t                             gen_req [motor_count];
  move_read_req_t                             grant;
  move_read_rsp_t                             rd_rsp;
  logic [motor_count-1:0]                     gen_idle;
  logic                                       queues_empty;

  // Internal reset held low until the counter saturates
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      reset_cnt <= '0;
    end else if (!core_resetn) begin
      reset_cnt <= reset_cnt + 1'b1;
    end
  end
  assign core_resetn = &reset_cnt;

  always_ff @(posedge CLK) begin
    if (!core_resetn) begin
      halt_q <= 1'b0;
    end else begin
      halt_q <= halt;
    end
  end
  assign halt_all = dec_flush | halt_q;             // Halt pin or halt command

  always_comb begin
    buffer_dtr   = 1'b1;
    queues_empty = 1'b1;
    for (int m = 0; m < motor_count; m++) begin
      if (fill_count[m] == count_bits'(queue_depth)) begin
        buffer_dtr = 1'b0;
      end
      if (fill_count[m] != '0) begin
        queues_empty = 1'b0;
      end
    end
  end
  assign move_done = queues_empty && (&gen_idle);

  spi_target u_spi (
    .CLK, .resetn(core_resetn), .sck, .cs, .copi, .cipo,
    .rx_byte, .rx_strobe, .frame_start, .frame_end, .tx_byte
  );

  command_decoder u_dec (
    .CLK, .resetn(core_resetn), .rx_byte, .rx_strobe, .frame_start, .frame_end,
    .tx_byte, .wr, .flush(dec_flush), .en_mask(en), .fill_count
  );

  move_buffer u_buf (
    .CLK, .resetn(core_resetn), .wr, .flush(halt_all),
    .rd_req(grant), .rd_rsp, .fill_count
  );

  move_arbiter u_arb (.CLK, .resetn(core_resetn), .req(gen_req), .grant);

  for (genvar g = 0; g < motor_count; g++) begin : g_motor
    step_generator u_gen (
      .CLK, .resetn(core_resetn), .index(motor_bits'(g)), .enable(en[g]),
      .halt(halt_all), .queue_nonempty(fill_count[g] != '0), .rd_req(gen_req[g]),
      .rd_rsp, .step(step[g]), .dir(dir[g]), .idle(gen_idle[g])
    );
  end

endmodule

//--- sim/tb_rap_core.sv
`timescale 1ns/1ns

module tb_rap_core;

  import rap_pkg::*;

  localparam int ring_size = 16;
  localparam int command_count = 24;                 // SPI frames sent over all tests
  localparam int fixed_move_cycles = 1800;           // Durations of the motion test
  localparam int random_move_cycles = 8 * 464;       // Upper bound of the random moves
  localparam int timeout_cycles = 264 + fixed_move_cycles + random_move_cycles
                                  + 2000 * command_count + 3000;

  logic                   CLK;
  logic                   resetn;
  logic                   sck;
  logic                   cs;
  logic                   copi;
  logic                   halt;
  logic                   cipo;
  logic [motor_count-1:0] step;
  logic [motor_count-1:0] dir;
  logic [motor_count-1:0] en;
  logic                   buffer_dtr;
  logic                   move_done;

  // Expected moves per motor, consumed pulse by pulse
  logic        pend_dir [motor_count][ring_size];
  int          pend_steps [motor_count][ring_size];
  int          pend_head [motor_count];
  int          pend_tail [motor_count];
  int          exp_total [motor_count];
  int          step_total [motor_count];
  int          model_fill [motor_count];
  logic [7:0]  frame_buf [8];
  logic        done_q = 1'b1;
  int          errors;
  int          errors_at_start;
  int          tests_failed;
  int          test_num;
  int          cycle_count = 0;

  rap_core uut (
    .CLK, .resetn, .sck, .cs, .copi, .cipo, .halt,
    .step, .dir, .en, .buffer_dtr, .move_done
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // Carries out of a 16-bit accumulator over the whole move
  function automatic int expected_steps(input logic [15:0] inc, input logic [15:0] dur);
    longint product;
    product = longint'(inc) * longint'(dur);
    return int'(product / 65536);
  endfunction

  task automatic log_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic begin_test();
    test_num++;
    errors_at_start = errors;
  endtask

  task automatic end_test(input string name);
    if (errors == errors_at_start) begin
      $display("Test %0d %s: PASS", test_num, name);
    end else begin
      $display("Test %0d %s: FAIL", test_num, name);
      tests_failed++;
    end
  endtask

  // Mode 0, 8 CLK cycles per bit, reply sampled just before rising SCK
  task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--) begin
      @(posedge CLK);
      sck  <= 1'b0;
      copi <= tx[i];
      repeat (4) @(posedge CLK);
      rx[i] = cipo;
      sck <= 1'b1;
      repeat (3) @(posedge CLK);
    end
  endtask

  task automatic spi_frame(input int n, output logic [7:0] last_rx);
    @(posedge CLK);
    cs <= 1'b0;
    repeat (8) @(posedge CLK);
    for (int i = 0; i < n; i++) begin
      spi_byte(frame_buf[i], last_rx);
    end
    @(posedge CLK);
    sck <= 1'b0;
    repeat (4) @(posedge CLK);
    cs <= 1'b1;
    repeat (16) @(posedge CLK);                      // Gap between frames
  endtask

  task automatic set_enable(input logic [7:0] mask);
    logic [7:0] rx;
    frame_buf[0] = cmd_set_enable;
    frame_buf[1] = mask;
    spi_frame(2, rx);
    if (en !== mask[motor_count-1:0]) begin
      log_mismatch($sformatf("en %b, expected %b", en, mask[motor_count-1:0]));
    end
  endtask

  task automatic queue_move(input int m, input logic d, input logic [15:0] inc,
                            input logic [15:0] dur, input bit accept);
    logic [7:0] rx;
    int         steps;
    steps = expected_steps(inc, dur);
    @(negedge CLK);
    if (accept) begin
      pend_dir[m][pend_tail[m]] = d;
      pend_steps[m][pend_tail[m]] = steps;
      pend_tail[m] = (pend_tail[m] + 1) % ring_size;
      model_fill[m]++;
    end
    frame_buf[0] = cmd_queue_move;
    frame_buf[1] = 8'(m);
    frame_buf[2] = {7'd0, d};
    frame_buf[3] = inc[15:8];
    frame_buf[4] = inc[7:0];
    frame_buf[5] = dur[15:8];
    frame_buf[6] = dur[7:0];
    spi_frame(7, rx);
    // Total grows only once the move sits in the queue
    @(negedge CLK);
    if (accept) begin
      exp_total[m] += steps;
    end
  endtask

  // Status nibbles hold the fill counts of motor 0 (low) and motor 1 (high)
  task automatic expect_status();
    logic [7:0] status;
    logic [7:0] expected;
    expected = {4'(model_fill[1]), 4'(model_fill[0])};
    frame_buf[0] = cmd_read_status;
    frame_buf[1] = 8'h00;
    spi_frame(2, status);
    if (status !== expected) begin
      log_mismatch($sformatf("status read 0x%02h, expected 0x%02h", status, expected));
    end
  endtask

  task automatic wait_move_done();
    while (move_done !== 1'b1) begin
      @(posedge CLK);
    end
    repeat (2) @(posedge CLK);                       // Let the step comparison run
    for (int m = 0; m < motor_count; m++) begin
      model_fill[m] = 0;
    end
  endtask

  // Steps are matched against the pending moves in queue order
  always @(posedge CLK) begin
    if (resetn) begin
      for (int m = 0; m < motor_count; m++) begin
        if (step[m]) begin
          step_total[m]++;
          while (pend_head[m] != pend_tail[m] && pend_steps[m][pend_head[m]] == 0) begin
            pend_head[m] = (pend_head[m] + 1) % ring_size;
          end
          if (pend_head[m] == pend_tail[m]) begin
            log_mismatch($sformatf("motor %0d stepped with no move pending", m));
          end else begin
            if (dir[m] !== pend_dir[m][pend_head[m]]) begin
              log_mismatch($sformatf("motor %0d dir %b, expected %b", m, dir[m],
                                     pend_dir[m][pend_head[m]]));
            end
            pend_steps[m][pend_head[m]]--;
          end
        end
      end
      if (move_done && !done_q) begin
        for (int m = 0; m < motor_count; m++) begin
          if (step_total[m] != exp_total[m]) begin
            log_mismatch($sformatf("motor %0d made %0d steps, expected %0d", m,
                                   step_total[m], exp_total[m]));
          end
        end
      end
      done_q = move_done;
    end
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == timeout_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    int snapshot [motor_count];
    void'($urandom(32'h97e1));
    resetn = 1'b0;
    sck    = 1'b0;
    cs     = 1'b1;
    copi   = 1'b0;
    halt   = 1'b0;
    repeat (4) @(posedge CLK);
    resetn <= 1'b1;
    repeat (260) @(posedge CLK);                     // Reset stretcher

    begin_test();
    if (buffer_dtr !== 1'b1 || move_done !== 1'b1) begin
      log_mismatch($sformatf("after reset dtr %b done %b", buffer_dtr, move_done));
    end
    if (step !== '0 || en !== '0 || cipo !== 1'b0 || dir !== '0) begin
      log_mismatch($sformatf("after reset step %b en %b cipo %b dir %b",
                             step, en, cipo, dir));
    end
    end_test("reset");

    begin_test();
    queue_move(0, 1'b1, 16'h4000, 16'd400, 1'b1);
    queue_move(0, 1'b0, 16'h8000, 16'd300, 1'b1);
    queue_move(1, 1'b0, 16'hc000, 16'd600, 1'b1);
    queue_move(0, 1'b1, 16'h1234, 16'd500, 1'b1);
    expect_status();
    if (move_done !== 1'b0) begin
      log_mismatch("move_done high with moves queued");
    end
    end_test("queue and status");

    begin_test();
    set_enable(8'h03);
    wait_move_done();
    expect_status();
    end_test("motion");

    begin_test();
    for (int i = 0; i < 8; i++) begin
      while (buffer_dtr !== 1'b1) begin
        @(posedge CLK);
      end
      queue_move($urandom % motor_count, 1'($urandom), 16'($urandom),
                 16'(64 + $urandom % 400), 1'b1);
    end
    wait_move_done();
    end_test("random moves");

    begin_test();
    set_enable(8'h00);
    for (int i = 0; i < queue_depth; i++) begin
      queue_move(1, 1'($urandom), 16'($urandom), 16'(100 + i), 1'b1);
    end
    if (buffer_dtr !== 1'b0) begin
      log_mismatch("buffer_dtr high with motor 1 queue full");
    end
    queue_move(1, 1'b1, 16'hffff, 16'd50, 1'b0);    // Dropped
    expect_status();
    end_test("full queue");

    begin_test();
    @(posedge CLK);
    halt <= 1'b1;
    @(negedge CLK);
    for (int m = 0; m < motor_count; m++) begin
      while (pend_head[m] != pend_tail[m]) begin
        exp_total[m] -= pend_steps[m][pend_head[m]];
        pend_head[m] = (pend_head[m] + 1) % ring_size;
      end
      model_fill[m] = 0;
    end
    @(posedge CLK);
    halt <= 1'b0;
    repeat (4) @(posedge CLK);
    if (buffer_dtr !== 1'b1 || move_done !== 1'b1) begin
      log_mismatch($sformatf("after halt dtr %b done %b", buffer_dtr, move_done));
    end
    expect_status();
    set_enable(8'h03);
    @(negedge CLK);
    snapshot = step_total;
    repeat (300) @(posedge CLK);
    @(negedge CLK);
    for (int m = 0; m < motor_count; m++) begin
      if (step_total[m] != snapshot[m]) begin
        log_mismatch($sformatf("motor %0d step pulses after halt", m));
      end
    end
    end_test("halt");

    $display("Tests run: %0d, tests failed: %0d, check errors: %0d",
             test_num, tests_failed, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- sim.f
rtl/rap_pkg.sv
rtl/spi_target.sv
rtl/command_decoder.sv
rtl/move_buffer.sv
rtl/move_arbiter.sv
rtl/step_generator.sv
rtl/rap_core.sv
sim/tb_rap_core.sv

//--- Bender.yml
package:
  name: rap_core

sources:
  - rtl/rap_pkg.sv
  - rtl/spi_target.sv
  - rtl/command_decoder.sv
  - rtl/move_buffer.sv
  - rtl/move_arbiter.sv
  - rtl/step_generator.sv
  - rtl/rap_core.sv
  - target: simulation
    files:
      - sim/tb_rap_core.sv
